/* logic/screen_pkg.sv */
`default_nettype none

package screen_pkg;

	////////////////////////////////////////////////////////////////////////////
	// counts and widths
	localparam int TICKS_PER_SEC  = 100;  // tick strobe runs at 100 Hz
	localparam int COUNT_SECONDS  = 66;   // shows up as 1:06
	localparam int DEBOUNCE_TICKS = 4;    // equal samples before the level flips
	localparam int LINE_CHARS     = 16;   // one lcd row
	localparam int LINE_W         = LINE_CHARS * 8;
	localparam int PRESCALE_W     = $clog2(TICKS_PER_SEC);
	localparam int DEBOUNCE_W     = $clog2(DEBOUNCE_TICKS);

	// start value split into bcd
	localparam logic [3:0] START_MIN  = 4'(COUNT_SECONDS / 60);
	localparam logic [3:0] START_TENS = 4'((COUNT_SECONDS % 60) / 10);
	localparam logic [3:0] START_ONES = 4'(COUNT_SECONDS % 10);

	////////////////////////////////////////////////////////////////////////////
	// keypad codes of the emote keys
	localparam logic [3:0] KEY_0 = 4'h0;
	localparam logic [3:0] KEY_1 = 4'h1;
	localparam logic [3:0] KEY_2 = 4'h2;
	localparam logic [3:0] KEY_4 = 4'h4;
	localparam logic [3:0] KEY_5 = 4'h5;
	localparam logic [3:0] KEY_7 = 4'h7;
	localparam logic [3:0] KEY_8 = 4'h8;
	localparam logic [3:0] KEY_A = 4'ha;

	// dialogue codes, emote d lives in graph slot d
	localparam logic [3:0] DLG_SMILE  = 4'd0;
	localparam logic [3:0] DLG_ANGRY  = 4'd1;
	localparam logic [3:0] DLG_SLEEPY = 4'd2;
	localparam logic [3:0] DLG_SHINE  = 4'd3;
	localparam logic [3:0] DLG_LOVE   = 4'd4;
	localparam logic [3:0] DLG_SAD    = 4'd5;
	localparam logic [3:0] DLG_LIKE   = 4'd6;
	localparam logic [3:0] DLG_RUDE   = 4'd7;
	localparam logic [3:0] DLG_NONE   = 4'd8;  // nothing to say

	////////////////////////////////////////////////////////////////////////////
	// ascii and layout
	localparam logic [7:0] CHAR_BLANK = 8'h20;  // space
	localparam logic [7:0] CHAR_COLON = 8'h3a;
	localparam logic [7:0] CHAR_ZERO  = 8'h30;  // digits are offsets from here

	localparam int POS_MIN   = 5;
	localparam int POS_COLON = 6;
	localparam int POS_GAP   = 7;
	localparam int POS_OWN   = 8;
	localparam int POS_TENS  = 9;
	localparam int POS_ONES  = 10;
	localparam int POS_PEER  = 11;

	// lcd byte, either plain ascii or a cgram slot (codes 0..7)
	typedef union packed {
		logic [7:0] ascii;
		struct packed {
			logic [4:0] prefix;  // zero for custom graphs
			logic [2:0] slot;
		} graph;
	} screen_char_t;

	localparam screen_char_t GLYPH_BLANK = screen_char_t'(CHAR_BLANK);

endpackage

`default_nettype wire

/* logic/key_debounce.sv */
`timescale 1ns/100ps
`default_nettype none

module key_debounce import screen_pkg::*; (
	input  logic       clk,
	input  logic       rst_n,
	input  logic       tick,       // 100 Hz sample strobe
	input  logic       pressed,    // raw level from the scanner
	input  logic [3:0] key,
	output logic       key_valid,  // debounced press level
	output logic [3:0] key_code    // held for the whole press
);

	logic [DEBOUNCE_W-1:0] run_cnt;  // differing samples seen in a row
	logic                  flip;     // this tick changes the level
	logic                  rise;

	assign flip = tick && (pressed != key_valid) &&
		(run_cnt == DEBOUNCE_W'(DEBOUNCE_TICKS - 1));
	assign rise = flip && pressed;

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			run_cnt   <= '0;
			key_valid <= 1'b0;
		end
		else if (tick)
		begin
			if (pressed == key_valid)
				run_cnt <= '0;  // glitch over, start again
			else if (flip)
			begin
				run_cnt   <= '0;
				key_valid <= pressed;  // 4th equal sample
			end
			else
				run_cnt <= run_cnt + 1'b1;
		end
	end

	always_ff @(posedge clk)
	begin
		if (rise)
			key_code <= key;  // grab code on the rising edge of the press
	end

endmodule

`default_nettype wire

/* logic/countdown_timer.sv */
`timescale 1ns/100ps
`default_nettype none

module countdown_timer import screen_pkg::*; (
	input  logic       clk,
	input  logic       rst_n,
	input  logic       tick,       // 100 Hz strobe
	input  logic       enable,     // from the game fsm
	output logic [3:0] min_digit,  // bcd
	output logic [3:0] sec_tens,   // bcd
	output logic [3:0] sec_ones,   // bcd
	output logic       time_up
);

	logic [PRESCALE_W-1:0] tick_cnt;  // ticks within the current second
	logic                  at_zero;   // display reads 0:00
	logic                  at_one;    // display reads 0:01
	logic                  sec_end;   // last tick of a second

	assign at_zero = (min_digit == 4'd0) && (sec_tens == 4'd0) && (sec_ones == 4'd0);
	assign at_one  = (min_digit == 4'd0) && (sec_tens == 4'd0) && (sec_ones == 4'd1);
	assign sec_end = tick && (tick_cnt == PRESCALE_W'(TICKS_PER_SEC - 1));

	////////////////////////////////////////////////////////////////////////////
	// tick prescaler
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			tick_cnt <= '0;
		else if (!enable || at_zero)
			tick_cnt <= '0;  // parked
		else if (sec_end)
			tick_cnt <= '0;  // wrap
		else if (tick)
			tick_cnt <= tick_cnt + 1'b1;
	end

	////////////////////////////////////////////////////////////////////////////
	// bcd seconds counter, decrement with borrow
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			min_digit <= START_MIN;
			sec_tens  <= START_TENS;
			sec_ones  <= START_ONES;
		end
		else if (!enable)
		begin
			min_digit <= START_MIN;  // reload while idle
			sec_tens  <= START_TENS;
			sec_ones  <= START_ONES;
		end
		else if (sec_end && !at_zero)
		begin
			if (sec_ones != 4'd0)
				sec_ones <= sec_ones - 4'd1;
			else
			begin
				sec_ones <= 4'd9;
				if (sec_tens != 4'd0)
					sec_tens <= sec_tens - 4'd1;
				else
				begin
					sec_tens  <= 4'd5;  // x:00 -> (x-1):59
					min_digit <= min_digit - 4'd1;
				end
			end
		end
	end

	// set on the same edge that lands on 0:00
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			time_up <= 1'b0;
		else if (!enable)
			time_up <= 1'b0;
		else if (sec_end && at_one)
			time_up <= 1'b1;  // sticky until enable drops
	end

endmodule

`default_nettype wire

/* logic/emote_codec.sv */
`timescale 1ns/100ps
`default_nettype none

module emote_codec import screen_pkg::*; (
	input  logic         key_valid,     // debounced press
	input  logic [3:0]   key_code,
	input  logic [3:0]   dialogue_in,   // from the other board
	output logic [3:0]   dialogue_out,  // to the other board
	output screen_char_t own_glyph,
	output screen_char_t peer_glyph
);

	// dialogue code to lcd byte
	function automatic screen_char_t glyph_of(input logic [3:0] code);
		screen_char_t g;
		if (code[3])
			g.ascii = CHAR_BLANK;  // 8..15 are not emotes
		else
		begin
			g.graph.prefix = 5'd0;
			g.graph.slot   = code[2:0];  // cgram slot equals the code
		end
		return g;
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// local key to outgoing dialogue
	always_comb
	begin
		dialogue_out = DLG_NONE;
		if (key_valid)
		begin
			case (key_code)
				KEY_A:   dialogue_out = DLG_SMILE;
				KEY_2:   dialogue_out = DLG_ANGRY;
				KEY_5:   dialogue_out = DLG_SLEEPY;
				KEY_8:   dialogue_out = DLG_SHINE;
				KEY_0:   dialogue_out = DLG_LOVE;
				KEY_1:   dialogue_out = DLG_SAD;
				KEY_4:   dialogue_out = DLG_LIKE;
				KEY_7:   dialogue_out = DLG_RUDE;
				default: dialogue_out = DLG_NONE;  // other keys say nothing
			endcase
		end
	end

	// both sides share the same code to glyph map
	always_comb
	begin
		own_glyph  = glyph_of(dialogue_out);
		peer_glyph = glyph_of(dialogue_in);
	end

endmodule

`default_nettype wire

/* logic/screen_composer.sv */
`timescale 1ns/100ps
`default_nettype none

module screen_composer import screen_pkg::*; (
	input  logic                clk,
	input  logic                rst_n,
	input  logic [3:0]          min_digit,
	input  logic [3:0]          sec_tens,
	input  logic [3:0]          sec_ones,
	input  screen_char_t        own_glyph,
	input  screen_char_t        peer_glyph,
	output logic [LINE_W-1:0]   data_out    // char 0 in the top byte
);

	logic [LINE_W-1:0] next_line;

	function automatic logic [LINE_W-1:0] build_line(
		input logic [3:0] m, input logic [3:0] t, input logic [3:0] o,
		input screen_char_t own, input screen_char_t peer);
		screen_char_t      line [LINE_CHARS];
		logic [LINE_W-1:0] flat;
		for (int i = 0; i < LINE_CHARS; i++)
			line[i] = GLYPH_BLANK;  // unused cells
		line[POS_MIN].ascii   = CHAR_ZERO + {4'h0, m};
		line[POS_COLON].ascii = CHAR_COLON;
		line[POS_GAP].ascii   = CHAR_BLANK;
		line[POS_OWN]         = own;
		line[POS_TENS].ascii  = CHAR_ZERO + {4'h0, t};
		line[POS_ONES].ascii  = CHAR_ZERO + {4'h0, o};
		line[POS_PEER]        = peer;
		for (int i = 0; i < LINE_CHARS; i++)
			flat[LINE_W - 8 * (i + 1) +: 8] = line[i];  // msb first
		return flat;
	endfunction

	assign next_line = build_line(min_digit, sec_tens, sec_ones, own_glyph, peer_glyph);

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			data_out <= build_line(START_MIN, START_TENS, START_ONES, GLYPH_BLANK,
				GLYPH_BLANK);  // 1:06, no emotes
		else
			data_out <= next_line;
	end

endmodule

`default_nettype wire

/* logic/count_down_screen.sv */
`timescale 1ns/100ps
`default_nettype none

module count_down_screen import screen_pkg::*; (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              tick,          // 100 Hz strobe
	input  logic              enable,        // game fsm runs the timer
	input  logic              pressed,       // raw keypad press
	input  logic [3:0]        key,
	input  logic [3:0]        dialogue_in,   // from the other board
	output logic              time_up,
	output logic [3:0]        dialogue_out,  // to the other board
	output logic [LINE_W-1:0] data_out       // 16 chars for the lcd
);

	logic         key_valid;
	logic [3:0]   key_code;
	logic [3:0]   min_digit;
	logic [3:0]   sec_tens;
	logic [3:0]   sec_ones;
	screen_char_t own_glyph;
	screen_char_t peer_glyph;

	key_debounce i_key_debounce (
		.clk       (clk),
		.rst_n     (rst_n),
		.tick      (tick),
		.pressed   (pressed),
		.key       (key),
		.key_valid (key_valid),
		.key_code  (key_code)
	);

	countdown_timer i_countdown_timer (
		.clk       (clk),
		.rst_n     (rst_n),
		.tick      (tick),
		.enable    (enable),
		.min_digit (min_digit),
		.sec_tens  (sec_tens),
		.sec_ones  (sec_ones),
		.time_up   (time_up)
	);

	emote_codec i_emote_codec (
		.key_valid    (key_valid),
		.key_code     (key_code),
		.dialogue_in  (dialogue_in),
		.dialogue_out (dialogue_out),
		.own_glyph    (own_glyph),
		.peer_glyph   (peer_glyph)
	);

	screen_composer i_screen_composer (
		.clk        (clk),
		.rst_n      (rst_n),
		.min_digit  (min_digit),
		.sec_tens   (sec_tens),
		.sec_ones   (sec_ones),
		.own_glyph  (own_glyph),
		.peer_glyph (peer_glyph),
		.data_out   (data_out)
	);

endmodule

`default_nettype wire

/* tests/tb_count_down_screen.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_count_down_screen import screen_pkg::*; ();

	// count-down and reload dominate the run length
	localparam int CYCLE_LIMIT = 2 * (COUNT_SECONDS * TICKS_PER_SEC + 3400);
	localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;  // x^32+x^22+x^2+x+1
	localparam logic [31:0] EMOTE_KEYS = {KEY_A, KEY_2, KEY_5, KEY_8,
		KEY_0, KEY_1, KEY_4, KEY_7};  // dialogue code 0 first

	logic              clk;
	logic              rst_n;
	logic              tick;
	logic              enable;
	logic              pressed;
	logic [3:0]        key;
	logic [3:0]        dialogue_in;
	logic              time_up;
	logic [3:0]        dialogue_out;
	logic [LINE_W-1:0] data_out;

	logic [31:0] lfsr = 32'h99a6_a515;
	int          cycles = 0;
	int          errors = 0;      // all mismatches
	int          test_errors;     // mismatches of the running test
	int          tests_run = 0;
	int          tests_failed = 0;
	string       cur_test;

	count_down_screen i_count_down_screen (
		.clk          (clk),
		.rst_n        (rst_n),
		.tick         (tick),
		.enable       (enable),
		.pressed      (pressed),
		.key          (key),
		.dialogue_in  (dialogue_in),
		.time_up      (time_up),
		.dialogue_out (dialogue_out),
		.data_out     (data_out)
	);

	initial
	begin
		clk = 1'b0;
		forever #4 clk = ~clk;  // 125 MHz
	end

	always @(posedge clk)
	begin
		cycles = cycles + 1;
		if (cycles >= CYCLE_LIMIT)
		begin
			$display("Run stopped: the tests did not finish within %0d cycles", CYCLE_LIMIT);
			$display("Errors found");
			$finish;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// random source and reference model
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ LFSR_TAPS) : (s >> 1);  // galois form shifting right
	endfunction

	task automatic draw(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++)
		begin
			v    = {v[30:0], lfsr[0]};  // one step per bit taken
			lfsr = lfsr_step(lfsr);
		end
	endtask

	function automatic logic [3:0] expected_code(input logic [3:0] k);
		logic [3:0] code;
		code = DLG_NONE;  // not an emote key
		for (int i = 0; i < 8; i++)
			if (EMOTE_KEYS[31 - 4 * i -: 4] == k)
				code = 4'(i);
		return code;
	endfunction

	function automatic screen_char_t expected_glyph(input logic [3:0] code);
		screen_char_t g;
		g.ascii = CHAR_BLANK;  // codes 8..15
		if (code < 4'd8)
		begin
			g.graph.prefix = 5'd0;
			g.graph.slot   = code[2:0];  // emote d in cgram slot d
		end
		return g;
	endfunction

	function automatic logic [LINE_W-1:0] expected_line(input int secs,
		input logic [3:0] own, input logic [3:0] peer);
		logic [LINE_W-1:0] line;
		screen_char_t      c;
		line = '0;
		for (int pos = 0; pos < LINE_CHARS; pos++)
		begin
			case (pos)
				5:       c.ascii = CHAR_ZERO + 8'(secs / 60);
				6:       c.ascii = CHAR_COLON;
				8:       c = expected_glyph(own);
				9:       c.ascii = CHAR_ZERO + 8'((secs % 60) / 10);
				10:      c.ascii = CHAR_ZERO + 8'(secs % 10);
				11:      c = expected_glyph(peer);
				default: c.ascii = CHAR_BLANK;
			endcase
			line = {line[LINE_W-9:0], c.ascii};  // char 0 ends up on top
		end
		return line;
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// compares and bookkeeping
	task automatic check_line(input logic [LINE_W-1:0] exp, input logic [LINE_W-1:0] act);
		if (act !== exp)
		begin
			$display("Error: %s line expected %h, actual %h", cur_test, exp, act);
			test_errors++;
		end
	endtask

	task automatic check_code(input logic [3:0] exp, input logic [3:0] act);
		if (act !== exp)
		begin
			$display("Error: %s dialogue expected %0d, actual %0d", cur_test, exp, act);
			test_errors++;
		end
	endtask

	task automatic check_flag(input logic exp, input logic act);
		if (act !== exp)
		begin
			$display("Error: %s time_up expected %b, actual %b", cur_test, exp, act);
			test_errors++;
		end
	endtask

	task automatic begin_test(input string name);
		cur_test    = name;
		test_errors = 0;
	endtask

	task automatic end_test();
		tests_run++;
		errors += test_errors;
		if (test_errors == 0)
			$display("test %s: pass", cur_test);
		else
		begin
			tests_failed++;
			$display("test %s: FAIL with %0d mismatches", cur_test, test_errors);
		end
	endtask

	// one tick strobe and a random quiet gap after it
	task automatic tick_once();
		logic [31:0] gap;
		tick = 1'b1;
		@(negedge clk);
		tick = 1'b0;
		draw(2, gap);
		repeat (gap[1:0]) @(negedge clk);
	endtask

	// full press and release of one key with enable low
	task automatic press_and_check(input logic [3:0] k);
		key     = k;
		pressed = 1'b1;
		repeat (DEBOUNCE_TICKS) tick_once();
		@(negedge clk);  // line registers one edge later
		check_code(expected_code(k), dialogue_out);
		check_line(expected_line(COUNT_SECONDS, expected_code(k), DLG_NONE), data_out);
		pressed = 1'b0;
		repeat (DEBOUNCE_TICKS) tick_once();
		check_code(DLG_NONE, dialogue_out);
	endtask

	////////////////////////////////////////////////////////////////////////////
	// tests
	task automatic reset_state();
		begin_test("reset_state");
		check_line(expected_line(COUNT_SECONDS, DLG_NONE, DLG_NONE), data_out);
		check_flag(1'b0, time_up);
		check_code(DLG_NONE, dialogue_out);
		end_test();
	endtask

	task automatic debounce_filter();
		logic [31:0] n;
		begin_test("debounce");
		draw(2, n);
		key     = KEY_5;
		pressed = 1'b1;
		repeat (n % 3 + 1)  // too short to count
		begin
			tick_once();
			check_code(DLG_NONE, dialogue_out);
		end
		pressed = 1'b0;
		repeat (DEBOUNCE_TICKS) tick_once();
		check_code(DLG_NONE, dialogue_out);
		pressed = 1'b1;
		repeat (DEBOUNCE_TICKS - 1) tick_once();
		check_code(DLG_NONE, dialogue_out);
		tick_once();  // the 4th high sample
		check_code(expected_code(KEY_5), dialogue_out);
		key = 4'h3;  // code must stay latched
		@(negedge clk);
		check_code(expected_code(KEY_5), dialogue_out);
		check_line(expected_line(COUNT_SECONDS, expected_code(KEY_5), DLG_NONE), data_out);
		pressed = 1'b0;
		repeat (DEBOUNCE_TICKS - 1) tick_once();
		check_code(expected_code(KEY_5), dialogue_out);
		tick_once();
		check_code(DLG_NONE, dialogue_out);
		end_test();
	endtask

	task automatic key_map();
		logic [31:0] r;
		begin_test("key_map");
		for (int i = 0; i < 8; i++)
			press_and_check(EMOTE_KEYS[31 - 4 * i -: 4]);
		repeat (4)
		begin
			draw(4, r);
			while (expected_code(r[3:0]) != DLG_NONE)
				draw(4, r);  // keep only non-emote keys
			press_and_check(r[3:0]);
		end
		end_test();
	endtask

	task automatic peer_side();
		logic [31:0] r;
		begin_test("peer_side");
		repeat (10)
		begin
			draw(4, r);
			dialogue_in = r[3:0];
			@(negedge clk);
			check_line(expected_line(COUNT_SECONDS, DLG_NONE, r[3:0]), data_out);
		end
		dialogue_in = DLG_NONE;
		@(negedge clk);
		end_test();
	endtask

	task automatic count_down();
		begin_test("count_down");
		enable = 1'b1;
		tick   = 1'b1;  // a tick on every edge
		for (int s = COUNT_SECONDS - 1; s >= 0; s--)
		begin
			repeat (s == COUNT_SECONDS - 1 ? TICKS_PER_SEC : TICKS_PER_SEC - 1)
				@(negedge clk);
			check_flag(s == 0, time_up);  // flag moves with the digits
			@(negedge clk);  // the line follows one edge later
			check_line(expected_line(s, DLG_NONE, DLG_NONE), data_out);
		end
		repeat (3 * TICKS_PER_SEC) @(negedge clk);  // held at 0:00
		check_line(expected_line(0, DLG_NONE, DLG_NONE), data_out);
		check_flag(1'b1, time_up);
		end_test();
	endtask

	task automatic reload_on_disable();
		begin_test("reload");
		enable = 1'b0;  // ticks keep coming
		@(negedge clk);
		check_flag(1'b0, time_up);
		@(negedge clk);
		check_line(expected_line(COUNT_SECONDS, DLG_NONE, DLG_NONE), data_out);
		repeat (2 * TICKS_PER_SEC) @(negedge clk);
		check_line(expected_line(COUNT_SECONDS, DLG_NONE, DLG_NONE), data_out);
		check_flag(1'b0, time_up);
		enable = 1'b1;  // prescaler must restart from zero
		repeat (TICKS_PER_SEC) @(negedge clk);
		check_line(expected_line(COUNT_SECONDS, DLG_NONE, DLG_NONE), data_out);
		@(negedge clk);
		check_line(expected_line(COUNT_SECONDS - 1, DLG_NONE, DLG_NONE), data_out);
		enable = 1'b0;
		tick   = 1'b0;
		@(negedge clk);
		end_test();
	endtask

	initial
	begin
		rst_n       = 1'b0;
		tick        = 1'b0;
		enable      = 1'b0;
		pressed     = 1'b0;
		key         = 4'h0;
		dialogue_in = DLG_NONE;
		repeat (4) @(negedge clk);  // 4 cycles in reset
		reset_state();  // registers still hold their reset values
		rst_n = 1'b1;
		@(negedge clk);
		debounce_filter();
		key_map();
		peer_side();
		count_down();
		reload_on_disable();
		$display("checks done: %0d tests, %0d failed, %0d mismatches",
			tests_run, tests_failed, errors);
		if (errors == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end

endmodule

`default_nettype wire

/* build.f */
logic/screen_pkg.sv
logic/key_debounce.sv
logic/countdown_timer.sv
logic/emote_codec.sv
logic/screen_composer.sv
logic/count_down_screen.sv
tests/tb_count_down_screen.sv

/* Bender.yml */
package:
  name: count_down_screen

sources:
  # package first, then leaf modules, then the top level
  - logic/screen_pkg.sv
  - logic/key_debounce.sv
  - logic/countdown_timer.sv
  - logic/emote_codec.sv
  - logic/screen_composer.sv
  - logic/count_down_screen.sv

  - target: test
    files:
      - tests/tb_count_down_screen.sv
